// File: include/huf_defines.svh
// size and width macros for the huffman code-length generator.
// include wherever a table size or field width is needed.

`ifndef HUF_DEFINES_SVH
`define HUF_DEFINES_SVH

// entries per frequency table.
`define HUF_N_SYM   16
`define HUF_SYM_W   4

`define HUF_FREQ_W  12
`define HUF_LEN_W   4   // code length.

// rebuild counter and limit.
`define HUF_REB_W   3

`endif

// File: src/huf_pkg.sv
// shared types of the huffman code-length generator.
// every module takes them with a wildcard import in its header.

`include "huf_defines.svh"

package huf_pkg;

  typedef struct packed {
    logic                   is_node;  // merged node, not a leaf.
    logic [`HUF_SYM_W-1:0]  id;       // symbol index or step number.
    logic [`HUF_FREQ_W-1:0] freq;
  } sym_entry_t;

  typedef struct packed {
    sym_entry_t [`HUF_N_SYM-1:0] list;          // sorted ascending.
    logic [`HUF_SYM_W:0]         first_used;    // HUF_N_SYM when empty.
    logic [`HUF_LEN_W-1:0]       max_code_len;
    logic [`HUF_REB_W-1:0]       rebuild_limit;
  } load_req_t;

  typedef enum logic [1:0] {DT_NONE, DT_CLEAR, DT_MERGE, DT_SINGLE} depth_op_e;

  typedef struct packed {
    depth_op_e             op;
    sym_entry_t            left;
    sym_entry_t            right;
    logic [`HUF_SYM_W-1:0] node_id;
  } merge_rec_t;

  typedef struct packed {
    logic [`HUF_N_SYM-1:0][`HUF_LEN_W-1:0] depths;  // by symbol.
    logic                                  zero_symbols;
    logic                                  build_error;
    logic [`HUF_REB_W-1:0]                 rebuild_count;
  } result_t;

  typedef enum logic [2:0] {
    ST_IDLE, ST_BUILD, ST_DRAIN, ST_CHECK, ST_REBUILD, ST_HOLD
  } ctrl_state_e;

endpackage

// File: src/freq_store.sv
// holds the loaded frequency table and its configuration.
// the table comes back shifted right by the rebuild count, nonzero
// entries floored at 1, so a rebuild keeps the original sort order.

`timescale 1ns/1ns
`include "huf_defines.svh"

module freq_store import huf_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  load_req_t                   load_req,
  input  logic [`HUF_REB_W-1:0]       rebuild_count,
  output sym_entry_t [`HUF_N_SYM-1:0] scaled_list,
  output logic [`HUF_SYM_W:0]         first_used,
  output logic [`HUF_LEN_W-1:0]       max_code_len,
  output logic [`HUF_REB_W-1:0]       rebuild_limit
);

  localparam int N = `HUF_N_SYM;
  localparam logic [`HUF_FREQ_W-1:0] FREQ_ONE = `HUF_FREQ_W'(1);

  sym_entry_t [N-1:0] list_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      first_used    <= '0;
      max_code_len  <= '0;
      rebuild_limit <= '0;
    end
    else if (start)
    begin
      first_used    <= load_req.first_used;
      max_code_len  <= load_req.max_code_len;
      rebuild_limit <= load_req.rebuild_limit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
      list_q <= load_req.list;
  end

  always_comb
  begin
    for (int i = 0; i < N; i++)
    begin
      scaled_list[i].is_node = 1'b0;
      scaled_list[i].id      = list_q[i].id;
      scaled_list[i].freq    = list_q[i].freq >> rebuild_count;
      if (list_q[i].freq != '0 && scaled_list[i].freq == '0)
        scaled_list[i].freq = FREQ_ONE;  // keep used symbols alive.
    end
  end

endmodule

// File: src/merge_list.sv
// sorted work list of the tree build.
// loads the scaled table a cycle after start or reload, then pops the two
// lightest entries per cycle and inserts their sum behind every entry of
// equal or lower frequency. each step goes out as a merge record.

`timescale 1ns/1ns
`include "huf_defines.svh"

module merge_list import huf_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic                        reload,
  input  sym_entry_t [`HUF_N_SYM-1:0] scaled_list,
  input  logic [`HUF_SYM_W:0]         first_used,
  output merge_rec_t                  merge_rec,
  output logic                        list_done
);

  localparam int N     = `HUF_N_SYM;
  localparam int CNT_W = `HUF_SYM_W + 1;
  localparam logic [CNT_W-1:0] N_CNT = CNT_W'(N);

  sym_entry_t [N-1:0]    wl;
  sym_entry_t [N-1:0]    nxt_wl;
  sym_entry_t            pop_a;
  sym_entry_t            pop_b;
  sym_entry_t            node;
  logic [CNT_W-1:0]      head;
  logic [CNT_W-1:0]      act_cnt;
  logic [`HUF_SYM_W-1:0] head_idx;
  logic [`HUF_SYM_W-1:0] step;
  logic                  load_pend;
  logic                  busy;
  logic                  do_merge;
  logic                  sorted_ok;

  assign head_idx = head[`HUF_SYM_W-1:0];
  assign act_cnt  = N_CNT - head;    // entries still active.
  assign do_merge = busy && act_cnt > CNT_W'(1);
  assign pop_a    = wl[head_idx];
  assign pop_b    = wl[head_idx + 1'b1];
  assign node     = '{is_node: 1'b1, id: step, freq: pop_a.freq + pop_b.freq};

  //////////////////////////////////////////////////
  // insertion. slot i takes its right neighbour while that one is no
  // heavier than the new node, then the node itself, then stays put.
  always_comb
  begin
    nxt_wl = wl;
    for (int i = 0; i < N; i++)
    begin
      if (i > int'(head))
      begin
        if (i < N - 1 && wl[(i + 1) % N].freq <= node.freq)
          nxt_wl[i] = wl[(i + 1) % N];
        else if (i == int'(head) + 1 || wl[i].freq <= node.freq)
          nxt_wl[i] = node;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (load_pend)
      wl <= scaled_list;
    else if (do_merge)
      wl <= nxt_wl;
  end

  //////////////////////////////////////////////////
  // step sequencing and record output.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      load_pend <= 1'b0;
      busy      <= 1'b0;
      head      <= N_CNT;
      step      <= '0;
      merge_rec <= '0;
      list_done <= 1'b0;
    end
    else
    begin
      load_pend    <= start | reload;  // table is valid a cycle later.
      list_done    <= 1'b0;
      merge_rec.op <= DT_NONE;
      if (load_pend)
      begin
        head         <= first_used;
        step         <= '0;
        busy         <= 1'b1;
        merge_rec.op <= DT_CLEAR;
      end
      else if (do_merge)
      begin
        head      <= head + 1'b1;
        step      <= step + 1'b1;
        merge_rec <= '{op: DT_MERGE, left: pop_a, right: pop_b, node_id: step};
      end
      else if (busy && act_cnt == CNT_W'(1) && step == '0)
      begin
        step      <= step + 1'b1;  // marks the lone symbol as sent.
        merge_rec <= '{op: DT_SINGLE, left: pop_a, right: '0, node_id: step};
      end
      else if (busy)
      begin
        busy      <= 1'b0;
        list_done <= 1'b1;
      end
    end
  end

  always_comb
  begin
    sorted_ok = 1'b1;
    for (int i = 1; i < N; i++)
      if (i > int'(head) && wl[i-1].freq > wl[i].freq)
        sorted_ok = 1'b0;
  end

  a_sorted: assert property (@(posedge clk) disable iff (!rst_n) busy |-> sorted_ok)
    else $error("merge_list: active entries out of order");

endmodule

// File: src/depth_tracker.sv
// per-symbol depth bookkeeping.
// each symbol remembers the root of the subtree it sits in. a merge of
// that root pushes the symbol one level deeper under the new node.
// records are registered on arrival and applied a cycle later.

`timescale 1ns/1ns
`include "huf_defines.svh"

module depth_tracker import huf_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  merge_rec_t                            merge_rec,
  input  logic [`HUF_LEN_W-1:0]                 max_code_len,
  output logic [`HUF_N_SYM-1:0][`HUF_LEN_W-1:0] depths,
  output logic                                  over_limit
);

  localparam int N     = `HUF_N_SYM;
  localparam int SYM_W = `HUF_SYM_W;

  merge_rec_t                rec_q;
  logic [N-1:0]              sym_vld;
  logic [N-1:0][SYM_W-1:0]   sym_root;

  function automatic logic is_leaf(sym_entry_t e, int i);
    return !e.is_node && e.id == SYM_W'(i);
  endfunction

  function automatic logic in_node(sym_entry_t e, int i);
    return e.is_node && sym_vld[i] && sym_root[i] == e.id;
  endfunction

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rec_q   <= '0;
      sym_vld <= '0;
      depths  <= '0;
    end
    else
    begin
      rec_q <= merge_rec;
      case (rec_q.op)
        DT_CLEAR:
        begin
          sym_vld <= '0;
          depths  <= '0;
        end
        DT_SINGLE:
        begin
          sym_vld[rec_q.left.id] <= 1'b1;
          depths[rec_q.left.id]  <= `HUF_LEN_W'(1);
        end
        DT_MERGE:
        begin
          for (int i = 0; i < N; i++)
          begin
            if (is_leaf(rec_q.left, i) || is_leaf(rec_q.right, i))
            begin
              sym_vld[i]  <= 1'b1;
              sym_root[i] <= rec_q.node_id;
              depths[i]   <= `HUF_LEN_W'(1);
            end
            else if (in_node(rec_q.left, i) || in_node(rec_q.right, i))
            begin
              sym_root[i] <= rec_q.node_id;
              depths[i]   <= depths[i] + 1'b1;
            end
          end
        end
        default: ;
      endcase
    end
  end

  always_comb
  begin
    over_limit = 1'b0;
    for (int i = 0; i < N; i++)
      if (depths[i] > max_code_len)
        over_limit = 1'b1;
  end

  // the list never hands out one entry twice in a step.
  a_pops_distinct: assert property (@(posedge clk) disable iff (!rst_n)
    merge_rec.op == DT_MERGE |->
      merge_rec.left.is_node != merge_rec.right.is_node ||
      merge_rec.left.id != merge_rec.right.id)
    else $error("depth_tracker: merge pops the same entry twice");

endmodule

// File: src/build_ctrl.sv
// sequencing of load, build, limit check, rebuild and result.
// a failed check rebuilds from scaled frequencies until the rebuild limit
// is reached, after which the result reports a build error.

`timescale 1ns/1ns
`include "huf_defines.svh"

module build_ctrl import huf_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  load_valid,
  output logic                                  load_ready,
  output logic                                  result_valid,
  input  logic                                  result_ready,
  input  logic [`HUF_SYM_W:0]                   first_used,
  input  logic [`HUF_LEN_W-1:0]                 max_code_len,
  input  logic [`HUF_REB_W-1:0]                 rebuild_limit,
  input  logic                                  list_done,
  input  logic [`HUF_N_SYM-1:0][`HUF_LEN_W-1:0] depths,
  input  logic                                  over_limit,
  output logic                                  start,
  output logic                                  reload,
  output logic [`HUF_REB_W-1:0]                 rebuild_count,
  output result_t                               result
);

  localparam int CNT_W = `HUF_SYM_W + 1;

  ctrl_state_e state;
  ctrl_state_e nxt_state;
  logic        give_up;

  assign load_ready   = state == ST_IDLE;
  assign result_valid = state == ST_HOLD;
  assign start        = load_valid && load_ready;
  assign reload       = state == ST_REBUILD;
  assign give_up      = rebuild_count == rebuild_limit;

  always_comb
  begin
    nxt_state = state;
    case (state)
      ST_IDLE:    if (load_valid) nxt_state = ST_BUILD;
      ST_BUILD:   if (list_done) nxt_state = ST_DRAIN;
      ST_DRAIN:   nxt_state = ST_CHECK;  // last record lands in the tracker.
      ST_CHECK:   nxt_state = (over_limit && !give_up) ? ST_REBUILD : ST_HOLD;
      ST_REBUILD: nxt_state = ST_BUILD;
      ST_HOLD:    if (result_ready) nxt_state = ST_IDLE;
      default:    nxt_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= ST_IDLE;
      rebuild_count <= '0;
    end
    else
    begin
      state <= nxt_state;
      if (start)
        rebuild_count <= '0;
      else if (reload)
        rebuild_count <= rebuild_count + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // result capture, held through the handshake.
  always_ff @(posedge clk)
  begin
    if (state == ST_CHECK && nxt_state == ST_HOLD)
    begin
      result.depths        <= over_limit ? '0 : depths;
      result.zero_symbols  <= first_used == CNT_W'(`HUF_N_SYM);
      result.build_error   <= over_limit;
      result.rebuild_count <= rebuild_count;
    end
  end

  function automatic logic depths_fit(logic [`HUF_N_SYM-1:0][`HUF_LEN_W-1:0] d);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < `HUF_N_SYM; i++)
      if (d[i] > max_code_len)
        ok = 1'b0;
    return ok;
  endfunction

  a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid && !result_ready |=> result_valid && $stable(result))
    else $error("build_ctrl: result changed under back-pressure");

  a_depth_fit: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid && !result.build_error |-> depths_fit(result.depths))
    else $error("build_ctrl: reported depth above max code length");

endmodule

// File: src/huf_tree_builder.sv
// huffman code-length generator, top level.
// takes a sorted frequency table over a valid/ready load port and returns
// per-symbol code lengths over a valid/ready result port.

`timescale 1ns/1ns
`include "huf_defines.svh"

module huf_tree_builder import huf_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      load_valid,
  output logic      load_ready,
  input  load_req_t load_req,
  output logic      result_valid,
  input  logic      result_ready,
  output result_t   result
);

  logic                                  start;
  logic                                  reload;
  logic [`HUF_REB_W-1:0]                 rebuild_count;
  sym_entry_t [`HUF_N_SYM-1:0]           scaled_list;
  logic [`HUF_SYM_W:0]                   first_used;
  logic [`HUF_LEN_W-1:0]                 max_code_len;
  logic [`HUF_REB_W-1:0]                 rebuild_limit;
  merge_rec_t                            merge_rec;
  logic                                  list_done;
  logic [`HUF_N_SYM-1:0][`HUF_LEN_W-1:0] depths;
  logic                                  over_limit;

  freq_store freq_store_i (
    .clk, .rst_n, .start, .load_req, .rebuild_count,
    .scaled_list, .first_used, .max_code_len, .rebuild_limit
  );

  merge_list merge_list_i (
    .clk, .rst_n, .start, .reload, .scaled_list, .first_used,
    .merge_rec, .list_done
  );

  depth_tracker depth_tracker_i (
    .clk, .rst_n, .merge_rec, .max_code_len, .depths, .over_limit
  );

  build_ctrl build_ctrl_i (
    .clk, .rst_n, .load_valid, .load_ready, .result_valid, .result_ready,
    .first_used, .max_code_len, .rebuild_limit, .list_done, .depths,
    .over_limit, .start, .reload, .rebuild_count, .result
  );

endmodule

// File: tests/tb_huf.sv
// testbench for the huffman code-length generator.
// loads sorted frequency tables, predicts every result with a reference
// model and compares each result handshake. stops at the first mismatch.

`timescale 1ns/1ns
`include "huf_defines.svh"

module tb_huf import huf_pkg::*;
();

  localparam int N       = `HUF_N_SYM;
  localparam int TIMEOUT = 1000;  // cycles per wait.

  logic      clk;
  logic      rst_n;
  logic      load_valid;
  logic      load_ready;
  load_req_t load_req;
  logic      result_valid;
  logic      result_ready;
  result_t   result;

  logic [31:0] rng = 32'd46;
  result_t     exp_q[$];
  int          sent = 0;
  int          checked = 0;

  huf_tree_builder dut_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // failure reporting.
  task automatic fail_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic expect_eq(input string name, input logic [71:0] got, input logic [71:0] want);
    assert (got === want)
    else
    begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
      fail_run();
    end
  endtask

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  //////////////////////////////////////////////////
  // reference model.
  function automatic logic [N-1:0][`HUF_LEN_W-1:0] tree_depths(load_req_t req, int shift);
    logic [N-1:0][`HUF_LEN_W-1:0] d;
    int           fq[N];
    logic [N-1:0] mask[N];
    int           n;
    int           nf;
    logic [N-1:0] nm;
    int           pos;
    d = '0;
    n = 0;
    for (int i = int'(req.first_used); i < N; i++)
    begin
      fq[n]   = int'(req.list[i].freq) >> shift;
      fq[n]   = (fq[n] == 0) ? 1 : fq[n];  // used symbols never drop to 0.
      mask[n] = N'(1) << req.list[i].id;
      n++;
    end
    if (n == 1)
      d[req.list[N-1].id] = `HUF_LEN_W'(1);
    while (n > 1)
    begin
      nf = fq[0] + fq[1];
      nm = mask[0] | mask[1];
      for (int s = 0; s < N; s++)
        if (nm[s])
          d[s] = d[s] + 1'b1;  // everything under the new node sinks a level.
      for (int k = 0; k < n - 2; k++)
      begin
        fq[k]   = fq[k+2];
        mask[k] = mask[k+2];
      end
      n   = n - 2;
      pos = 0;
      while (pos < n && fq[pos] <= nf)
        pos++;
      for (int k = n; k > pos; k--)
      begin
        fq[k]   = fq[k-1];
        mask[k] = mask[k-1];
      end
      fq[pos]   = nf;
      mask[pos] = nm;
      n++;
    end
    return d;
  endfunction

  function automatic result_t ref_model(load_req_t req);
    result_t                      r;
    logic [N-1:0][`HUF_LEN_W-1:0] d;
    logic                         over;
    r = '0;
    if (req.first_used == (`HUF_SYM_W+1)'(N))
    begin
      r.zero_symbols = 1'b1;
      return r;
    end
    for (int cnt = 0; cnt < (1 << `HUF_REB_W); cnt++)
    begin
      d    = tree_depths(req, cnt);
      over = 1'b0;
      for (int i = 0; i < N; i++)
        if (d[i] > req.max_code_len)
          over = 1'b1;
      r.rebuild_count = `HUF_REB_W'(cnt);
      if (!over)
      begin
        r.depths = d;
        return r;
      end
      if (cnt == int'(req.rebuild_limit))
      begin
        r.build_error = 1'b1;  // depths stay 0.
        return r;
      end
    end
    return r;
  endfunction

  // sorts per-symbol frequencies into a load request, stable on ties.
  function automatic load_req_t pack_table(input int f[N], input int max_len, input int limit);
    load_req_t req;
    int        ids[N];
    int        fs[N];
    int        tmp;
    for (int i = 0; i < N; i++)
    begin
      ids[i] = i;
      fs[i]  = f[i];
    end
    for (int i = 1; i < N; i++)
      for (int j = i; j > 0 && fs[j-1] > fs[j]; j--)
      begin
        tmp      = fs[j];
        fs[j]    = fs[j-1];
        fs[j-1]  = tmp;
        tmp      = ids[j];
        ids[j]   = ids[j-1];
        ids[j-1] = tmp;
      end
    req            = '0;
    req.first_used = (`HUF_SYM_W+1)'(N);
    for (int i = N - 1; i >= 0; i--)
    begin
      req.list[i].id   = `HUF_SYM_W'(ids[i]);
      req.list[i].freq = `HUF_FREQ_W'(fs[i]);
      if (fs[i] != 0)
        req.first_used = (`HUF_SYM_W+1)'(i);
    end
    req.max_code_len  = `HUF_LEN_W'(max_len);
    req.rebuild_limit = `HUF_REB_W'(limit);
    return req;
  endfunction

  task automatic make_random_table(input int max_len, output load_req_t req);
    int f[N];
    for (int i = 0; i < N; i++)
    begin
      rng  = xorshift32(rng);
      f[i] = (rng[3:0] == 4'd0) ? 0 : int'(rng[11:4]);  // sum stays below 4096.
    end
    req = pack_table(f, max_len, 7);
  endtask

  //////////////////////////////////////////////////
  // load and result handshakes, called on a falling edge.
  task automatic send_table(input load_req_t req);
    int n;
    n = 0;
    while (!load_ready)
    begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
      begin
        $display("timeout while waiting for load_ready");
        fail_run();
      end
    end
    load_valid = 1'b1;
    load_req   = req;
    exp_q.push_back(ref_model(req));
    sent++;
    @(negedge clk);
    load_valid = 1'b0;
  endtask

  task automatic collect_result(input int hold, input int max_len);
    result_t held;
    int      n;
    n = 0;
    while (!result_valid)
    begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
      begin
        $display("timeout while waiting for result_valid");
        fail_run();
      end
    end
    held = result;
    for (int i = 0; i < N; i++)
      assert (held.build_error || held.depths[i] <= max_len)
      else
      begin
        $display("CHECK FAILED at %0t: result.depths[%0d] got %0d expected at most %0d",
                 $time, i, held.depths[i], max_len);
        fail_run();
      end
    for (int k = 0; k < hold; k++)
    begin
      load_valid = 1'b1;  // offered while the result is still pending.
      @(negedge clk);
      expect_eq("result", 72'(result), 72'(held));
      expect_eq("result_valid", 72'(result_valid), 72'(1));
      expect_eq("load_ready", 72'(load_ready), 72'(0));
    end
    load_valid   = 1'b0;
    result_ready = 1'b1;
    @(negedge clk);
    result_ready = 1'b0;
    expect_eq("result_valid", 72'(result_valid), 72'(0));
    expect_eq("load_ready", 72'(load_ready), 72'(1));
  endtask

  // compare process, one expected result per handshake.
  always @(posedge clk)
  begin
    result_t want;
    if (rst_n && result_valid && result_ready)
    begin
      if (exp_q.size() == 0)
      begin
        $display("result handshake at %0t with no load outstanding", $time);
        fail_run();
      end
      want = exp_q.pop_front();
      expect_eq("result.depths", 72'(result.depths), 72'(want.depths));
      expect_eq("result.zero_symbols", 72'(result.zero_symbols), 72'(want.zero_symbols));
      expect_eq("result.build_error", 72'(result.build_error), 72'(want.build_error));
      expect_eq("result.rebuild_count", 72'(result.rebuild_count), 72'(want.rebuild_count));
      checked++;
    end
  end

  //////////////////////////////////////////////////
  // stimulus.
  initial
  begin
    load_req_t req;
    result_t   fib_exp;
    int        f[N];
    int        n;
    rst_n        = 1'b0;
    load_valid   = 1'b0;
    load_req     = '0;
    result_ready = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    expect_eq("result_valid", 72'(result_valid), 72'(0));
    expect_eq("load_ready", 72'(load_ready), 72'(1));

    for (int t = 0; t < 12; t++)
    begin
      make_random_table(15, req);
      send_table(req);
      collect_result(0, 15);
    end

    // empty table, then one used symbol.
    for (int i = 0; i < N; i++)
      f[i] = 0;
    send_table(pack_table(f, 15, 7));
    collect_result(0, 15);
    f[9] = 37;
    send_table(pack_table(f, 15, 7));
    collect_result(0, 15);

    // fibonacci weights on ten symbols give a depth of 9 before scaling.
    f[0] = 1;
    f[1] = 1;
    for (int i = 2; i < N; i++)
      f[i] = (i < 10) ? f[i-1] + f[i-2] : 0;
    req     = pack_table(f, 5, 7);
    fib_exp = ref_model(req);
    assert (fib_exp.rebuild_count != 0 && !fib_exp.build_error)
    else
    begin
      $display("steep table does not lead to a successful rebuild");
      fail_run();
    end
    send_table(req);
    collect_result(0, 5);
    send_table(pack_table(f, 5, 0));
    collect_result(0, 5);

    // back-pressure on the result port.
    for (int t = 0; t < 4; t++)
    begin
      make_random_table(15, req);
      send_table(req);
      rng = xorshift32(rng);
      collect_result(1 + int'(rng[2:0]), 15);
    end

    n = 0;
    while (checked != sent)
    begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
      begin
        $display("timeout while waiting for the last results to be compared");
        fail_run();
      end
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
src/huf_pkg.sv
src/freq_store.sv
src/merge_list.sv
src/depth_tracker.sv
src/build_ctrl.sv
src/huf_tree_builder.sv
tests/tb_huf.sv

// File: run.sh
#!/usr/bin/env bash
# builds the huffman code-length testbench with verilator and runs it.
# the exit status of the run is the exit status of the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_huf -o tb_huf_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_huf_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0
